// ==== eu_cfg_pkg.sv ====
/*
 * event unit configuration
 * sizes, event line positions and the per-core event word type
 */
`default_nettype none

package eu_cfg_pkg;

  localparam int MAX_CORES = 8;
  localparam int CORE_ID_W = 3;
  localparam int EVT_W     = 32;

  // bit positions inside each core's event word
  localparam int SW_EVT_BASE  = 0;
  localparam int BARR_EVT_BIT = 8;
  localparam int SOC_EVT_BIT  = 9;
  localparam int EXT_EVT_BASE = 12;

  typedef logic [EVT_W-1:0]     eu_evt_t;
  typedef logic [MAX_CORES-1:0] core_mask_t;

endpackage

`default_nettype wire

// ==== eu_cmd_pkg.sv ====
/*
 * event unit command format
 * opcodes, the argument union and the command/response words of a core port
 */
`default_nettype none

package eu_cmd_pkg;

  typedef enum logic [2:0] {
    OP_SET_MASK    = 3'd0,
    OP_TRIG_SW     = 3'd1,
    OP_BARR_CFG    = 3'd2,
    OP_BARR_ARRIVE = 3'd3,
    OP_WAIT        = 3'd4,
    OP_SOC_POP     = 3'd5
  } eu_op_e;

  // id selects the sw event or the barrier, cores is the target/participant set
  typedef struct packed {
    logic [eu_cfg_pkg::EVT_W-eu_cfg_pkg::CORE_ID_W-eu_cfg_pkg::MAX_CORES-1:0] pad;
    logic [eu_cfg_pkg::CORE_ID_W-1:0]                                        id;
    eu_cfg_pkg::core_mask_t                                                  cores;
  } eu_target_t;

  typedef union packed {
    eu_cfg_pkg::eu_evt_t mask;
    eu_target_t          target;
  } eu_arg_u;

  typedef struct packed {
    eu_op_e  op;
    eu_arg_u arg;
  } eu_cmd_t;

  typedef logic [eu_cfg_pkg::EVT_W-1:0] eu_resp_t;

endpackage

`default_nettype wire

// ==== eu_sw_evt_trig.sv ====
/*
 * software event trigger
 * merges the triggers of all cores and sends one registered pulse per event id
 * to every addressed core
 */
`timescale 1ns/1ps
`default_nettype none

module eu_sw_evt_trig #(
  parameter int NB_CORES  = 4,
  parameter int NB_SW_EVT = 8
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [NB_CORES-1:0]                 trig_valid_i,
  input  eu_cmd_pkg::eu_target_t [NB_CORES-1:0] trig_i,
  output logic [NB_CORES-1:0][NB_SW_EVT-1:0]  sw_evt_o
);

  logic [NB_CORES-1:0][NB_SW_EVT-1:0] sw_evt_d;

  // every source may address several targets at once
  always_comb begin
    sw_evt_d = '0;
    for (int src = 0; src < NB_CORES; src++) begin
      for (int dst = 0; dst < NB_CORES; dst++) begin
        for (int e = 0; e < NB_SW_EVT; e++) begin
          if (trig_valid_i[src] && trig_i[src].cores[dst] && (int'(trig_i[src].id) == e)) begin
            sw_evt_d[dst][e] = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sw_evt_o <= '0;
    end else begin
      sw_evt_o <= sw_evt_d;
    end
  end

endmodule

`default_nettype wire

// ==== eu_barrier_unit.sv ====
/*
 * hardware barriers
 * each barrier keeps a participant set and the set of cores that arrived,
 * and pulses an event to all participants once everyone is in
 */
`timescale 1ns/1ps
`default_nettype none

module eu_barrier_unit #(
  parameter int NB_CORES = 4,
  parameter int NB_BARR  = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic [NB_CORES-1:0]                   cfg_valid_i,
  input  logic [NB_CORES-1:0]                   arrive_valid_i,
  input  eu_cmd_pkg::eu_target_t [NB_CORES-1:0] target_i,
  output logic [NB_CORES-1:0]                   barr_evt_o
);

  logic [NB_BARR-1:0][NB_CORES-1:0] part_q;
  logic [NB_BARR-1:0][NB_CORES-1:0] arrived_q;
  logic [NB_BARR-1:0]               barr_done;
  logic [NB_CORES-1:0]              barr_evt_d;

  always_comb begin
    barr_evt_d = '0;
    for (int b = 0; b < NB_BARR; b++) begin
      barr_done[b] = (part_q[b] != '0) && (arrived_q[b] == part_q[b]);
      if (barr_done[b]) begin
        barr_evt_d = barr_evt_d | part_q[b];
      end
    end
  end

  // a config write overrides an arrival at the same barrier in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      part_q     <= '0;
      arrived_q  <= '0;
      barr_evt_o <= '0;
    end else begin
      barr_evt_o <= barr_evt_d;
      for (int b = 0; b < NB_BARR; b++) begin
        if (barr_done[b]) begin
          arrived_q[b] <= '0;
        end
        for (int c = 0; c < NB_CORES; c++) begin
          if (arrive_valid_i[c] && (int'(target_i[c].id) == b)) begin
            arrived_q[b][c] <= 1'b1;
          end
        end
        for (int c = 0; c < NB_CORES; c++) begin
          if (cfg_valid_i[c] && (int'(target_i[c].id) == b)) begin
            part_q[b]    <= target_i[c].cores[NB_CORES-1:0];
            arrived_q[b] <= '0;
          end
        end
      end
    end
  end

  // cores must only arrive at barriers that exist
  for (genvar c = 0; c < NB_CORES; c++) begin : g_arrive_chk
    assert property (@(posedge clk_i) disable iff (rst_i)
      arrive_valid_i[c] |-> (int'(target_i[c].id) < NB_BARR));
  end

endmodule

`default_nettype wire

// ==== eu_soc_evt_fifo.sv ====
/*
 * SoC peripheral event FIFO
 * circular buffer of event IDs, popped by the lowest-index requesting core
 */
`timescale 1ns/1ps
`default_nettype none

module eu_soc_evt_fifo #(
  parameter int NB_CORES       = 4,
  parameter int SOC_FIFO_DEPTH = 4,
  parameter int EVNT_WIDTH     = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  evt_valid_i,
  output logic                  evt_ready_o,
  input  logic [EVNT_WIDTH-1:0] evt_data_i,
  input  logic [NB_CORES-1:0]   pop_req_i,
  output logic [NB_CORES-1:0]   pop_gnt_o,
  output logic [EVNT_WIDTH-1:0] head_o,
  output logic                  not_empty_o
);

  localparam int PTR_W = (SOC_FIFO_DEPTH > 1) ? $clog2(SOC_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(SOC_FIFO_DEPTH + 1);

  logic [EVNT_WIDTH-1:0] mem_q [SOC_FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q;
  logic                  push;
  logic                  pop;

  assign evt_ready_o = (count_q != CNT_W'(SOC_FIFO_DEPTH));
  assign not_empty_o = (count_q != '0);
  assign head_o      = mem_q[rd_ptr_q];
  assign push        = evt_valid_i && evt_ready_o;
  // a grant is the popping core's handshake
  assign pop         = |pop_gnt_o;

  // walk down so the lowest requester ends up with the grant
  always_comb begin
    pop_gnt_o = '0;
    if (not_empty_o) begin
      for (int c = NB_CORES - 1; c >= 0; c--) begin
        if (pop_req_i[c]) begin
          pop_gnt_o    = '0;
          pop_gnt_o[c] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(SOC_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(SOC_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= evt_data_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    count_q <= CNT_W'(SOC_FIFO_DEPTH));
  assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(pop_gnt_o));

endmodule

`default_nettype wire

// ==== eu_core_unit.sv ====
/*
 * per-core event unit
 * buffers incoming events, decodes the core's commands, gates the core clock
 * during a wait and returns wait and pop results
 */
`timescale 1ns/1ps
`default_nettype none

module eu_core_unit #(
  parameter int EVNT_WIDTH = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  eu_cmd_pkg::eu_cmd_t    cmd_i,
  input  eu_cfg_pkg::eu_evt_t    evt_lines_i,
  output logic                   sw_trig_valid_o,
  output logic                   barr_cfg_valid_o,
  output logic                   barr_arrive_valid_o,
  output eu_cmd_pkg::eu_target_t target_o,
  output logic                   pop_req_o,
  input  logic                   pop_gnt_i,
  input  logic [EVNT_WIDTH-1:0]  soc_head_i,
  output logic                   resp_valid_o,
  output eu_cmd_pkg::eu_resp_t   resp_o,
  output logic                   clock_en_o
);

  import eu_cfg_pkg::*;
  import eu_cmd_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_POP} state_e;

  state_e  state_q;
  eu_evt_t evt_buf_q;
  eu_evt_t evt_mask_q;
  eu_evt_t evt_hit;
  logic    evt_hit_any;
  logic    cmd_accept;

  assign evt_hit     = evt_buf_q & evt_mask_q;
  assign evt_hit_any = |evt_hit;

  // a pop is taken from ST_POP once the FIFO grants this core
  assign cmd_ready_o = ((state_q == ST_IDLE) && !(cmd_valid_i && cmd_i.op == OP_SOC_POP)) ||
                       ((state_q == ST_POP) && pop_gnt_i);
  assign cmd_accept  = cmd_valid_i && cmd_ready_o;

  assign sw_trig_valid_o     = cmd_accept && (cmd_i.op == OP_TRIG_SW);
  assign barr_cfg_valid_o    = cmd_accept && (cmd_i.op == OP_BARR_CFG);
  assign barr_arrive_valid_o = cmd_accept && (cmd_i.op == OP_BARR_ARRIVE);
  assign target_o            = cmd_i.arg.target;
  assign pop_req_o           = (state_q == ST_POP) && cmd_valid_i;

  // core sleeps only while waiting on nothing
  assign clock_en_o = !((state_q == ST_WAIT) && !evt_hit_any);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= ST_IDLE;
      evt_buf_q    <= '0;
      evt_mask_q   <= '0;
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= 1'b0;
      evt_buf_q    <= evt_buf_q | evt_lines_i;
      case (state_q)
        ST_IDLE: begin
          if (cmd_accept) begin
            if (cmd_i.op == OP_SET_MASK) begin
              evt_mask_q <= cmd_i.arg.mask;
            end
            if (cmd_i.op == OP_WAIT) begin
              state_q <= ST_WAIT;
            end
          end else if (cmd_valid_i && cmd_i.op == OP_SOC_POP) begin
            state_q <= ST_POP;
          end
        end
        ST_WAIT: begin
          if (evt_hit_any) begin
            // returned bits are consumed, new arrivals still land
            evt_buf_q    <= (evt_buf_q & ~evt_hit) | evt_lines_i;
            resp_valid_o <= 1'b1;
            state_q      <= ST_IDLE;
          end
        end
        ST_POP: begin
          if (cmd_accept) begin
            resp_valid_o <= 1'b1;
            state_q      <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == ST_WAIT) && evt_hit_any) begin
      resp_o <= evt_hit;
    end else if ((state_q == ST_POP) && cmd_accept) begin
      resp_o <= EVT_W'(soc_head_i);
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i) resp_valid_o |=> !resp_valid_o);

endmodule

`default_nettype wire

// ==== event_unit_top.sv ====
/*
 * cluster event unit top level
 * maps sw, barrier, SoC FIFO and external events onto each core's event word
 * and connects the per-core units to the shared blocks
 */
`timescale 1ns/1ps
`default_nettype none

module event_unit_top #(
  parameter int NB_CORES       = 4,
  parameter int NB_SW_EVT      = 8,
  parameter int NB_BARR        = 4,
  parameter int SOC_FIFO_DEPTH = 4,
  parameter int EVNT_WIDTH     = 8
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [NB_CORES-1:0]                 cmd_valid_i,
  output logic [NB_CORES-1:0]                 cmd_ready_o,
  input  eu_cmd_pkg::eu_cmd_t [NB_CORES-1:0]  cmd_i,
  output logic [NB_CORES-1:0]                 resp_valid_o,
  output eu_cmd_pkg::eu_resp_t [NB_CORES-1:0] resp_o,
  output logic [NB_CORES-1:0]                 core_clock_en_o,
  input  logic [NB_CORES-1:0][3:0]            ext_events_i,
  input  logic                                soc_evt_valid_i,
  output logic                                soc_evt_ready_o,
  input  logic [EVNT_WIDTH-1:0]               soc_evt_data_i
);

  import eu_cfg_pkg::*;
  import eu_cmd_pkg::*;

  logic [NB_CORES-1:0]                sw_trig_valid;
  logic [NB_CORES-1:0]                barr_cfg_valid;
  logic [NB_CORES-1:0]                barr_arrive_valid;
  eu_target_t [NB_CORES-1:0]          core_target;
  logic [NB_CORES-1:0][NB_SW_EVT-1:0] sw_evt;
  logic [NB_CORES-1:0]                barr_evt;
  logic [NB_CORES-1:0]                pop_req;
  logic [NB_CORES-1:0]                pop_gnt;
  logic [EVNT_WIDTH-1:0]              soc_head;
  logic                               soc_not_empty;
  eu_evt_t [NB_CORES-1:0]             evt_lines;

  // event map, unused positions stay zero
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      evt_lines[c]                           = '0;
      evt_lines[c][SW_EVT_BASE +: NB_SW_EVT] = sw_evt[c];
      evt_lines[c][BARR_EVT_BIT]             = barr_evt[c];
      evt_lines[c][SOC_EVT_BIT]              = soc_not_empty;
      evt_lines[c][EXT_EVT_BASE +: 4]        = ext_events_i[c];
    end
  end

  eu_sw_evt_trig #(
    .NB_CORES  ( NB_CORES  ),
    .NB_SW_EVT ( NB_SW_EVT )
  ) eu_sw_evt_trig_i (
    .clk_i        ( clk_i         ),
    .rst_i        ( rst_i         ),
    .trig_valid_i ( sw_trig_valid ),
    .trig_i       ( core_target   ),
    .sw_evt_o     ( sw_evt        )
  );

  eu_barrier_unit #(
    .NB_CORES ( NB_CORES ),
    .NB_BARR  ( NB_BARR  )
  ) eu_barrier_unit_i (
    .clk_i          ( clk_i             ),
    .rst_i          ( rst_i             ),
    .cfg_valid_i    ( barr_cfg_valid    ),
    .arrive_valid_i ( barr_arrive_valid ),
    .target_i       ( core_target       ),
    .barr_evt_o     ( barr_evt          )
  );

  eu_soc_evt_fifo #(
    .NB_CORES       ( NB_CORES       ),
    .SOC_FIFO_DEPTH ( SOC_FIFO_DEPTH ),
    .EVNT_WIDTH     ( EVNT_WIDTH     )
  ) eu_soc_evt_fifo_i (
    .clk_i       ( clk_i           ),
    .rst_i       ( rst_i           ),
    .evt_valid_i ( soc_evt_valid_i ),
    .evt_ready_o ( soc_evt_ready_o ),
    .evt_data_i  ( soc_evt_data_i  ),
    .pop_req_i   ( pop_req         ),
    .pop_gnt_o   ( pop_gnt         ),
    .head_o      ( soc_head        ),
    .not_empty_o ( soc_not_empty   )
  );

  for (genvar i = 0; i < NB_CORES; i++) begin : EU_CORE
    eu_core_unit #(
      .EVNT_WIDTH ( EVNT_WIDTH )
    ) eu_core_unit_i (
      .clk_i               ( clk_i                ),
      .rst_i               ( rst_i                ),
      .cmd_valid_i         ( cmd_valid_i[i]       ),
      .cmd_ready_o         ( cmd_ready_o[i]       ),
      .cmd_i               ( cmd_i[i]             ),
      .evt_lines_i         ( evt_lines[i]         ),
      .sw_trig_valid_o     ( sw_trig_valid[i]     ),
      .barr_cfg_valid_o    ( barr_cfg_valid[i]    ),
      .barr_arrive_valid_o ( barr_arrive_valid[i] ),
      .target_o            ( core_target[i]       ),
      .pop_req_o           ( pop_req[i]           ),
      .pop_gnt_i           ( pop_gnt[i]           ),
      .soc_head_i          ( soc_head             ),
      .resp_valid_o        ( resp_valid_o[i]      ),
      .resp_o              ( resp_o[i]            ),
      .clock_en_o          ( core_clock_en_o[i]   )
    );
  end

endmodule

`default_nettype wire

// ==== tb_event_unit.sv ====
/*
 * event unit testbench
 * applies a table of core commands, SoC pushes and ext events to the top level
 * and checks responses, sleep state and SoC back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module tb_event_unit;

  import eu_cfg_pkg::*;
  import eu_cmd_pkg::*;

  localparam int NB_CORES       = 4;
  localparam int SOC_FIFO_DEPTH = 4;
  localparam int EVNT_WIDTH     = 8;
  localparam int RESP_SLOTS     = 16;

  typedef enum logic [2:0] {ROW_CMD, ROW_STAT, ROW_PUSH, ROW_SOC_RDY, ROW_EXT} row_kind_e;

  // resp doubles as push data, ext line value or expected {ready, clock_en}
  typedef struct packed {
    row_kind_e kind;
    logic [7:0] core;
    eu_cmd_t    cmd;
    logic       has_resp;
    eu_resp_t   resp;
    logic       no_wait;
  } row_t;

  logic                           clk;
  logic                           rst;
  logic [NB_CORES-1:0]            cmd_valid;
  logic [NB_CORES-1:0]            cmd_ready;
  eu_cmd_t [NB_CORES-1:0]         cmd;
  logic [NB_CORES-1:0]            resp_valid;
  eu_resp_t [NB_CORES-1:0]        resp;
  logic [NB_CORES-1:0]            clk_en;
  logic [NB_CORES-1:0][3:0]       ext_events;
  logic                           soc_valid;
  logic                           soc_ready;
  logic [EVNT_WIDTH-1:0]          soc_data;

  row_t                  rows[$];
  eu_resp_t              exp_resp [NB_CORES][RESP_SLOTS];
  int                    issued [NB_CORES] = '{default: 0};
  int                    seen [NB_CORES] = '{default: 0};
  logic [EVNT_WIDTH-1:0] soc_vals [SOC_FIFO_DEPTH];
  int                    seed = 32'hd93af48f;
  int                    cycles = 0;
  int                    limit;

  event_unit_top #(
    .NB_CORES       ( NB_CORES       ),
    .NB_SW_EVT      ( 8              ),
    .NB_BARR        ( 4              ),
    .SOC_FIFO_DEPTH ( SOC_FIFO_DEPTH ),
    .EVNT_WIDTH     ( EVNT_WIDTH     )
  ) event_unit_top_i (
    .clk_i           ( clk        ),
    .rst_i           ( rst        ),
    .cmd_valid_i     ( cmd_valid  ),
    .cmd_ready_o     ( cmd_ready  ),
    .cmd_i           ( cmd        ),
    .resp_valid_o    ( resp_valid ),
    .resp_o          ( resp       ),
    .core_clock_en_o ( clk_en     ),
    .ext_events_i    ( ext_events ),
    .soc_evt_valid_i ( soc_valid  ),
    .soc_evt_ready_o ( soc_ready  ),
    .soc_evt_data_i  ( soc_data   )
  );

  always #20 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  function automatic eu_evt_t evt_bit(input int pos);
    return eu_evt_t'(1) << pos;
  endfunction

  function automatic eu_cmd_t plain_cmd(input eu_op_e op);
    eu_cmd_t c;
    c    = '0;
    c.op = op;
    return c;
  endfunction

  function automatic eu_cmd_t mask_cmd(input eu_evt_t mask);
    eu_cmd_t c;
    c          = plain_cmd(OP_SET_MASK);
    c.arg.mask = mask;
    return c;
  endfunction

  function automatic eu_cmd_t target_cmd(input eu_op_e op, input int id, input int cores);
    eu_cmd_t c;
    c                  = plain_cmd(op);
    c.arg.target.id    = CORE_ID_W'(id);
    c.arg.target.cores = core_mask_t'(cores);
    return c;
  endfunction

  task automatic add_row(input row_kind_e kind, input int core, input eu_cmd_t c,
                         input logic has_resp, input eu_resp_t r, input logic no_wait);
    row_t row;
    row.kind     = kind;
    row.core     = 8'(core);
    row.cmd      = c;
    row.has_resp = has_resp;
    row.resp     = r;
    row.no_wait  = no_wait;
    rows.push_back(row);
  endtask

  task automatic build_table();
    for (int i = 0; i < SOC_FIFO_DEPTH; i++) begin
      soc_vals[i] = EVNT_WIDTH'($random(seed));
    end
    // sw events, consumed bits do not return
    add_row(ROW_CMD, 1, mask_cmd(evt_bit(SW_EVT_BASE + 3) | evt_bit(SW_EVT_BASE + 4)), 0, '0, 0);
    add_row(ROW_CMD, 0, target_cmd(OP_TRIG_SW, 3, 'b0110), 0, '0, 0);
    add_row(ROW_CMD, 1, plain_cmd(OP_WAIT), 1, evt_bit(SW_EVT_BASE + 3), 0);
    add_row(ROW_CMD, 0, target_cmd(OP_TRIG_SW, 4, 'b0010), 0, '0, 0);
    add_row(ROW_CMD, 1, plain_cmd(OP_WAIT), 1, evt_bit(SW_EVT_BASE + 4), 0);
    // core 2 sleeps until a masked trigger shows up
    add_row(ROW_CMD, 2, mask_cmd(evt_bit(SW_EVT_BASE + 5)), 0, '0, 0);
    add_row(ROW_CMD, 2, plain_cmd(OP_WAIT), 1, evt_bit(SW_EVT_BASE + 5), 0);
    add_row(ROW_STAT, 2, plain_cmd(OP_WAIT), 0, 32'h0, 1);
    add_row(ROW_CMD, 0, target_cmd(OP_TRIG_SW, 5, 'b0100), 0, '0, 1);
    add_row(ROW_STAT, 2, plain_cmd(OP_WAIT), 0, 32'h3, 0);
    // barrier 1 with cores 0 and 1
    add_row(ROW_CMD, 0, mask_cmd(evt_bit(BARR_EVT_BIT)), 0, '0, 0);
    add_row(ROW_CMD, 1, mask_cmd(evt_bit(BARR_EVT_BIT)), 0, '0, 0);
    add_row(ROW_CMD, 0, target_cmd(OP_BARR_CFG, 1, 'b0011), 0, '0, 0);
    add_row(ROW_CMD, 0, target_cmd(OP_BARR_ARRIVE, 1, 0), 0, '0, 0);
    add_row(ROW_CMD, 0, plain_cmd(OP_WAIT), 1, evt_bit(BARR_EVT_BIT), 0);
    add_row(ROW_STAT, 0, plain_cmd(OP_WAIT), 0, 32'h0, 1);
    add_row(ROW_CMD, 1, target_cmd(OP_BARR_ARRIVE, 1, 0), 0, '0, 1);
    // fill the SoC FIFO, then drain it in order
    for (int i = 0; i < SOC_FIFO_DEPTH; i++) begin
      add_row(ROW_PUSH, 0, plain_cmd(OP_WAIT), 0, eu_resp_t'(soc_vals[i]), 0);
    end
    add_row(ROW_SOC_RDY, 0, plain_cmd(OP_WAIT), 0, 32'h0, 0);
    add_row(ROW_CMD, 2, mask_cmd(evt_bit(SOC_EVT_BIT)), 0, '0, 0);
    add_row(ROW_CMD, 2, plain_cmd(OP_WAIT), 1, evt_bit(SOC_EVT_BIT), 0);
    for (int i = 0; i < SOC_FIFO_DEPTH; i++) begin
      add_row(ROW_CMD, 2, plain_cmd(OP_SOC_POP), 1, eu_resp_t'(soc_vals[i]), 0);
    end
    // a one-cycle ext pulse stays buffered
    add_row(ROW_CMD, 3, mask_cmd(evt_bit(EXT_EVT_BASE + 2)), 0, '0, 0);
    add_row(ROW_EXT, 3, plain_cmd(OP_WAIT), 0, 32'h4, 0);
    add_row(ROW_CMD, 3, plain_cmd(OP_WAIT), 1, evt_bit(EXT_EVT_BASE + 2), 0);
  endtask

  function automatic logic responses_pending();
    for (int c = 0; c < NB_CORES; c++) begin
      if (issued[c] != seen[c]) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic wait_for_responses();
    while (responses_pending()) begin
      @(posedge clk);
      #2;
    end
  endtask

  // every row starts and ends 2 ns after a rising edge
  task automatic apply_row(input row_t r);
    int c;
    c = int'(r.core);
    case (r.kind)
      ROW_CMD: begin
        if (r.has_resp) begin
          exp_resp[c][issued[c]] = r.resp;
          issued[c]++;
        end
        cmd_valid[c] = 1'b1;
        cmd[c]       = r.cmd;
        @(negedge clk);
        while (!cmd_ready[c]) @(negedge clk);
        @(posedge clk);
        #2;
        cmd_valid[c] = 1'b0;
        cmd[c]       = '0;
      end
      ROW_STAT: begin
        repeat (2) @(negedge clk);
        assert ({cmd_ready[c], clk_en[c]} == r.resp[1:0]) else
          report_failure($sformatf("Mismatch {cmd_ready_o,core_clock_en_o}[%0d]: got %h, expected %h",
                                   c, {cmd_ready[c], clk_en[c]}, r.resp[1:0]));
        @(posedge clk);
        #2;
      end
      ROW_PUSH: begin
        soc_valid = 1'b1;
        soc_data  = r.resp[EVNT_WIDTH-1:0];
        @(negedge clk);
        while (!soc_ready) @(negedge clk);
        @(posedge clk);
        #2;
        soc_valid = 1'b0;
      end
      ROW_SOC_RDY: begin
        @(negedge clk);
        assert (soc_ready == r.resp[0]) else
          report_failure($sformatf("Mismatch soc_evt_ready_o: got %h, expected %h",
                                   soc_ready, r.resp[0]));
        @(posedge clk);
        #2;
      end
      default: begin
        ext_events[c] = r.resp[3:0];
        @(posedge clk);
        #2;
        ext_events[c] = '0;
      end
    endcase
  endtask

  // response checker and cycle limit
  always @(negedge clk) begin
    if (!rst) begin
      cycles = cycles + 1;
      if (cycles >= limit) begin
        report_failure("timeout: the table did not complete within the cycle limit");
      end
      for (int c = 0; c < NB_CORES; c++) begin
        if (resp_valid[c]) begin
          assert (issued[c] != seen[c]) else
            report_failure($sformatf("core %0d gave a response that no command asked for", c));
          assert (resp[c] == exp_resp[c][seen[c]]) else
            report_failure($sformatf("Mismatch resp_o[%0d]: got %h, expected %h",
                                     c, resp[c], exp_resp[c][seen[c]]));
          seen[c] = seen[c] + 1;
        end
      end
    end
  end

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    cmd_valid  = '0;
    cmd        = '0;
    ext_events = '0;
    soc_valid  = 1'b0;
    soc_data   = '0;
    build_table();
    limit = 50 * rows.size();
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    foreach (rows[i]) begin
      if (!rows[i].no_wait) begin
        wait_for_responses();
      end
      apply_row(rows[i]);
    end
    wait_for_responses();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
eu_cfg_pkg.sv
eu_cmd_pkg.sv
eu_sw_evt_trig.sv
eu_barrier_unit.sv
eu_soc_evt_fifo.sv
eu_core_unit.sv
event_unit_top.sv
tb_event_unit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the event unit testbench, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f list.f --top-module tb_event_unit -o tb_event_unit || exit 1
./obj_dir/tb_event_unit 2>&1 | tee sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
